// File: design/sdram_bank_tracker.sv
`timescale 1ns/10ps
`default_nettype none
`include "sdram_macros.svh"

module sdram_bank_tracker (
    input  logic             clk,
    input  logic             rst,
    input  sdram_pkg::bank_t bank,
    input  sdram_pkg::row_t  row,
    input  logic             open_row,
    input  logic             close_bank,
    input  logic             close_all,
    output logic             open,
    output logic             hit
);
    import sdram_pkg::*;

    // one open flag and one row per bank
    logic [`SDRAM_NUM_BANKS-1:0] open_q;
    row_t                        rows_q [`SDRAM_NUM_BANKS];

    always_ff @(posedge clk) begin
        if (rst || close_all) begin
            open_q <= '0;
        end else if (close_bank) begin
            open_q[bank] <= 1'b0;
        end else if (open_row) begin
            open_q[bank] <= 1'b1;
        end
    end

    // row only matters while the open flag is set
    always_ff @(posedge clk) begin
        if (open_row) begin
            rows_q[bank] <= row;
        end
    end

    // lookup for the presented bank
    assign open = open_q[bank];
    assign hit  = open_q[bank] && (rows_q[bank] == row);

endmodule

`default_nettype wire

// File: design/sdram_cmd_if.sv
`timescale 1ns/10ps
`default_nettype none

// one sdram command per cycle, nop when idle
interface sdram_cmd_if;
    import sdram_pkg::*;

    sdram_cmd_e cmd;
    bank_t      ba;
    pin_addr_t  a;
    // write data, only meaningful with a write command
    word_t      wdata;
    // marks a read so the pin stage can capture its data
    logic       is_read;

    modport issuer (
        output cmd,
        output ba,
        output a,
        output wdata,
        output is_read
    );

    modport pins (
        input cmd,
        input ba,
        input a,
        input wdata,
        input is_read
    );

endinterface

`default_nettype wire

// File: design/sdram_controller.sv
`timescale 1ns/10ps
`default_nettype none

module sdram_controller (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic                  rw,
    input  sdram_pkg::user_addr_t user_addr,
    input  sdram_pkg::word_t      data_in,
    output sdram_pkg::word_t      data_out,
    output logic                  out_valid,
    output logic                  sdram_cke,
    output logic                  sdram_cs,
    output logic                  sdram_ras,
    output logic                  sdram_cas,
    output logic                  sdram_we,
    output sdram_pkg::bank_t      sdram_ba,
    output sdram_pkg::pin_addr_t  sdram_a,
    output sdram_pkg::word_t      sdram_dqo,
    output logic                  dq_oe,
    input  sdram_pkg::word_t      sdram_dqi
);
    import sdram_pkg::*;

    logic  refresh_req;
    logic  refresh_ack;
    logic  hit;
    logic  open;
    bank_t req_bank;
    row_t  req_row;
    logic  open_row;
    logic  close_bank;
    logic  close_all;
    logic  cke;

    // sequencer to pin stage
    sdram_cmd_if cmd_bus ();

    sdram_refresh_timer u_refresh (
        .clk         (clk),
        .rst         (rst),
        .refresh_ack (refresh_ack),
        .refresh_req (refresh_req)
    );

    sdram_bank_tracker u_banks (
        .clk        (clk),
        .rst        (rst),
        .bank       (req_bank),
        .row        (req_row),
        .open_row   (open_row),
        .close_bank (close_bank),
        .close_all  (close_all),
        .open       (open),
        .hit        (hit)
    );

    sdram_sequencer u_seq (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .rw          (rw),
        .user_addr   (user_addr),
        .data_in     (data_in),
        .refresh_req (refresh_req),
        .refresh_ack (refresh_ack),
        .hit         (hit),
        .open        (open),
        .req_bank    (req_bank),
        .req_row     (req_row),
        .open_row    (open_row),
        .close_bank  (close_bank),
        .close_all   (close_all),
        .cke         (cke),
        .cmd         (cmd_bus.issuer)
    );

    sdram_phy u_phy (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd_bus.pins),
        .cke_in    (cke),
        .sdram_cke (sdram_cke),
        .sdram_cs  (sdram_cs),
        .sdram_ras (sdram_ras),
        .sdram_cas (sdram_cas),
        .sdram_we  (sdram_we),
        .sdram_ba  (sdram_ba),
        .sdram_a   (sdram_a),
        .sdram_dqo (sdram_dqo),
        .dq_oe     (dq_oe),
        .sdram_dqi (sdram_dqi),
        .data_out  (data_out),
        .out_valid (out_valid)
    );

endmodule

`default_nettype wire

// File: design/sdram_macros.svh
`ifndef SDRAM_MACROS_SVH
`define SDRAM_MACROS_SVH

// timing in controller clock cycles, 3-3-3 part

// active to read or write
`define SDRAM_T_RCD 3

// precharge to next command
`define SDRAM_T_RP 3

// refresh to next command
`define SDRAM_T_RFC 7

// read command to data on the pins
`define SDRAM_CAS_LATENCY 3

// cycles between auto-refresh requests
`define SDRAM_REFRESH_INTERVAL 750

// geometry
`define SDRAM_NUM_BANKS 4

// mode register: write burst follows burst length, std op, cas 3, sequential, burst 1
`define SDRAM_MODE_WORD 13'h030

`endif

// File: design/sdram_phy.sv
`timescale 1ns/10ps
`default_nettype none
`include "sdram_macros.svh"

module sdram_phy (
    input  logic                 clk,
    input  logic                 rst,
    sdram_cmd_if.pins            cmd,
    input  logic                 cke_in,
    output logic                 sdram_cke,
    output logic                 sdram_cs,
    output logic                 sdram_ras,
    output logic                 sdram_cas,
    output logic                 sdram_we,
    output sdram_pkg::bank_t     sdram_ba,
    output sdram_pkg::pin_addr_t sdram_a,
    output sdram_pkg::word_t     sdram_dqo,
    output logic                 dq_oe,
    input  sdram_pkg::word_t     sdram_dqi,
    output sdram_pkg::word_t     data_out,
    output logic                 out_valid
);
    import sdram_pkg::*;

    localparam int CL = `SDRAM_CAS_LATENCY;

    sdram_cmd_e cmd_q;
    logic       cke_q;
    // read markers, bit k set k cycles after the read hit the pins
    logic [CL:0] rd_pipe;

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_q     <= CMD_UNSELECTED;
            cke_q     <= 1'b0;
            dq_oe     <= 1'b0;
            rd_pipe   <= '0;
            out_valid <= 1'b0;
        end else begin
            cmd_q     <= cmd.cmd;
            cke_q     <= cke_in;
            // drive dq only while the write is on the pins
            dq_oe     <= (cmd.cmd == CMD_WRITE);
            rd_pipe   <= {rd_pipe[CL-1:0], cmd.is_read};
            out_valid <= rd_pipe[CL];
        end
    end

    always_ff @(posedge clk) begin
        sdram_ba  <= cmd.ba;
        sdram_a   <= cmd.a;
        sdram_dqo <= cmd.wdata;
        // data valid cas latency after the chip sampled the read
        if (rd_pipe[CL]) begin
            data_out <= sdram_dqi;
        end
    end

    assign {sdram_cs, sdram_ras, sdram_cas, sdram_we} = cmd_q;
    assign sdram_cke = cke_q;

endmodule

`default_nettype wire

// File: design/sdram_pkg.sv
`default_nettype none

package sdram_pkg;

    // user address fields
    typedef logic [12:0] row_t;
    typedef logic [1:0]  bank_t;
    typedef logic [7:0]  col_t;

    // {row, bank, col}: row 22:10, bank 9:8, col 7:0
    typedef logic [22:0] user_addr_t;

    typedef logic [31:0] word_t;
    typedef logic [12:0] pin_addr_t;

    // encoded as {cs, ras, cas, we}
    typedef enum logic [3:0] {
        CMD_UNSELECTED = 4'b1000,
        CMD_NOP        = 4'b0111,
        CMD_ACTIVE     = 4'b0011,
        CMD_READ       = 4'b0101,
        CMD_WRITE      = 4'b0100,
        CMD_PRECHARGE  = 4'b0010,
        CMD_REFRESH    = 4'b0001,
        CMD_LOAD_MODE  = 4'b0000
    } sdram_cmd_e;

    typedef enum logic [3:0] {
        S_INIT,
        S_LOAD_MODE,
        S_IDLE,
        S_PRECHARGE,
        S_REFRESH,
        S_ACTIVATE,
        S_READ,
        S_WRITE,
        S_WAIT
    } seq_state_e;

endpackage

`default_nettype wire

// File: design/sdram_refresh_timer.sv
`timescale 1ns/10ps
`default_nettype none
`include "sdram_macros.svh"

module sdram_refresh_timer (
    input  logic clk,
    input  logic rst,
    input  logic refresh_ack,
    output logic refresh_req
);
    localparam int CNT_W = $clog2(`SDRAM_REFRESH_INTERVAL);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`SDRAM_REFRESH_INTERVAL - 1);

    logic [CNT_W-1:0] count_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            count_q     <= '0;
            refresh_req <= 1'b0;
        end else if (refresh_ack) begin
            // served, start a fresh interval
            count_q     <= '0;
            refresh_req <= 1'b0;
        end else if (count_q == CNT_LAST) begin
            count_q     <= '0;
            // sticky until the sequencer gets to it
            refresh_req <= 1'b1;
        end else begin
            count_q <= count_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: design/sdram_sequencer.sv
`timescale 1ns/10ps
`default_nettype none
`include "sdram_macros.svh"

module sdram_sequencer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic                  rw,
    input  sdram_pkg::user_addr_t user_addr,
    input  sdram_pkg::word_t      data_in,
    input  logic                  refresh_req,
    output logic                  refresh_ack,
    input  logic                  hit,
    input  logic                  open,
    output sdram_pkg::bank_t      req_bank,
    output sdram_pkg::row_t       req_row,
    output logic                  open_row,
    output logic                  close_bank,
    output logic                  close_all,
    output logic                  cke,
    sdram_cmd_if.issuer           cmd
);
    import sdram_pkg::*;

    // wait loads T-2: one cycle in the issuing state plus delay+1 in WAIT
    localparam logic [3:0] DLY_RCD = 4'(`SDRAM_T_RCD - 2);
    localparam logic [3:0] DLY_RP  = 4'(`SDRAM_T_RP - 2);
    localparam logic [3:0] DLY_RFC = 4'(`SDRAM_T_RFC - 2);
    // tMRD of two cycles
    localparam logic [3:0] DLY_MRD = 4'd0;

    seq_state_e state_q;
    seq_state_e next_q;
    logic [3:0] delay_q;
    logic       armed_q;
    logic       cke_q;
    logic       pre_all_q;

    // one-entry request queue
    logic       q_full;
    logic       q_rw;
    user_addr_t q_addr;
    word_t      q_data;

    // request being worked on
    logic       op_rw;
    user_addr_t op_addr;
    word_t      op_data;

    logic accept;
    logic take;

    assign in_ready = armed_q && !q_full;
    assign accept   = in_valid && in_ready;
    // refresh wins over a queued request
    assign take     = (state_q == S_IDLE) && !refresh_req && q_full;

    // idle looks up the queued request, later states the active one
    assign req_bank = (state_q == S_IDLE) ? q_addr[9:8] : op_addr[9:8];
    assign req_row  = (state_q == S_IDLE) ? q_addr[22:10] : op_addr[22:10];
    assign cke      = cke_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= S_INIT;
            next_q    <= S_IDLE;
            delay_q   <= '0;
            armed_q   <= 1'b0;
            cke_q     <= 1'b0;
            pre_all_q <= 1'b0;
            q_full    <= 1'b0;
        end else begin
            if (accept) begin
                q_full <= 1'b1;
            end
            case (state_q)
                S_INIT: begin
                    cke_q   <= 1'b1;
                    state_q <= S_LOAD_MODE;
                end
                S_LOAD_MODE: begin
                    delay_q <= DLY_MRD;
                    next_q  <= S_IDLE;
                    state_q <= S_WAIT;
                end
                S_IDLE: begin
                    // first idle opens the user port
                    armed_q <= 1'b1;
                    if (refresh_req) begin
                        // close everything before refresh
                        pre_all_q <= 1'b1;
                        next_q    <= S_REFRESH;
                        state_q   <= S_PRECHARGE;
                    end else if (q_full) begin
                        q_full    <= 1'b0;
                        pre_all_q <= 1'b0;
                        if (hit) begin
                            state_q <= q_rw ? S_WRITE : S_READ;
                        end else if (open) begin
                            // other row open in this bank
                            next_q  <= S_ACTIVATE;
                            state_q <= S_PRECHARGE;
                        end else begin
                            state_q <= S_ACTIVATE;
                        end
                    end
                end
                S_PRECHARGE: begin
                    delay_q <= DLY_RP;
                    state_q <= S_WAIT;
                end
                S_REFRESH: begin
                    delay_q <= DLY_RFC;
                    next_q  <= S_IDLE;
                    state_q <= S_WAIT;
                end
                S_ACTIVATE: begin
                    delay_q <= DLY_RCD;
                    next_q  <= op_rw ? S_WRITE : S_READ;
                    state_q <= S_WAIT;
                end
                S_READ, S_WRITE: begin
                    state_q <= S_IDLE;
                end
                S_WAIT: begin
                    if (delay_q == '0) begin
                        state_q <= next_q;
                    end else begin
                        delay_q <= delay_q - 1'b1;
                    end
                end
                default: state_q <= S_INIT;
            endcase
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if (accept) begin
            q_rw   <= rw;
            q_addr <= user_addr;
            q_data <= data_in;
        end
        if (take) begin
            op_rw   <= q_rw;
            op_addr <= q_addr;
            op_data <= q_data;
        end
    end

    // command for this cycle, registered again in the pin stage
    always_comb begin
        cmd.cmd     = CMD_NOP;
        cmd.ba      = op_addr[9:8];
        // full 8-bit column on the address pins
        cmd.a       = pin_addr_t'(op_addr[7:0]);
        cmd.wdata   = op_data;
        cmd.is_read = 1'b0;
        refresh_ack = 1'b0;
        open_row    = 1'b0;
        close_bank  = 1'b0;
        close_all   = 1'b0;
        case (state_q)
            S_IDLE: begin
                refresh_ack = refresh_req;
            end
            S_LOAD_MODE: begin
                cmd.cmd = CMD_LOAD_MODE;
                cmd.ba  = '0;
                cmd.a   = `SDRAM_MODE_WORD;
            end
            S_PRECHARGE: begin
                cmd.cmd    = CMD_PRECHARGE;
                cmd.a      = '0;
                // a10 selects all banks
                cmd.a[10]  = pre_all_q;
                close_all  = pre_all_q;
                close_bank = !pre_all_q;
            end
            S_REFRESH: begin
                cmd.cmd = CMD_REFRESH;
            end
            S_ACTIVATE: begin
                cmd.cmd  = CMD_ACTIVE;
                cmd.a    = op_addr[22:10];
                open_row = 1'b1;
            end
            S_READ: begin
                cmd.cmd     = CMD_READ;
                cmd.is_read = 1'b1;
            end
            S_WRITE: begin
                cmd.cmd = CMD_WRITE;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+design
design/sdram_pkg.sv
design/sdram_cmd_if.sv
design/sdram_refresh_timer.sv
design/sdram_bank_tracker.sv
design/sdram_sequencer.sv
design/sdram_phy.sv
design/sdram_controller.sv
testbench/sdram_chip_model.sv
testbench/tb_sdram_controller.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f files.f --top-module tb_sdram_controller -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "STATUS: PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: testbench/sdram_chip_model.sv
`timescale 1ns/10ps
`default_nettype none
`include "sdram_macros.svh"

// behavioral single-rank sdram, one word per column, burst length 1
module sdram_chip_model (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cs,
    input  logic                 ras,
    input  logic                 cas,
    input  logic                 we,
    input  sdram_pkg::bank_t     ba,
    input  sdram_pkg::pin_addr_t a,
    input  sdram_pkg::word_t     dqo,
    input  logic                 dq_oe,
    output sdram_pkg::word_t     dqi,
    output int                   protocol_errors,
    output int                   read_cmds,
    output int                   write_cmds,
    output int                   refresh_cmds
);
    import sdram_pkg::*;

    localparam int CL = `SDRAM_CAS_LATENCY;
    localparam int REF_LIMIT = `SDRAM_REFRESH_INTERVAL + 40;

    word_t      mem [user_addr_t];
    logic       bank_open [`SDRAM_NUM_BANKS];
    row_t       open_rows [`SDRAM_NUM_BANKS];
    int         last_act [`SDRAM_NUM_BANKS];
    int         last_pre;
    int         last_ref;
    // start of the current refresh window
    int         ref_mark;
    int         cycle;
    // read data on its way out, last stage drives dq
    word_t      rd_data [CL];
    sdram_cmd_e pin_cmd;

    assign pin_cmd = sdram_cmd_e'({cs, ras, cas, we});
    assign dqi     = rd_data[CL-1];

    function automatic word_t fetch(user_addr_t addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        // never written, address pattern
        return word_t'(addr) ^ 32'h5a5a5a5a;
    endfunction

    task automatic flag(input string what);
        protocol_errors++;
        $display("%0t chip model: %s", $time, what);
    endtask

    always @(posedge clk) begin
        user_addr_t addr;
        logic       any_open;
        addr = {open_rows[ba], ba, a[7:0]};
        any_open = 1'b0;
        for (int i = 0; i < `SDRAM_NUM_BANKS; i++) begin
            any_open = any_open | bank_open[i];
        end
        if (rst) begin
            cycle    = 0;
            last_pre = -100;
            last_ref = -100;
            ref_mark = 0;
            for (int i = 0; i < `SDRAM_NUM_BANKS; i++) begin
                bank_open[i] = 1'b0;
                last_act[i]  = -100;
            end
            for (int i = 0; i < CL; i++) begin
                rd_data[i] <= '0;
            end
        end else begin
            cycle++;
            for (int i = CL - 1; i > 0; i--) begin
                rd_data[i] <= rd_data[i-1];
            end
            rd_data[0] <= '0;
            assert (cycle - ref_mark <= REF_LIMIT) else begin
                flag("no refresh within the refresh interval");
                // one report per missed window
                ref_mark = cycle;
            end
            if (pin_cmd != CMD_NOP && pin_cmd != CMD_UNSELECTED) begin
                assert (cycle - last_pre >= `SDRAM_T_RP) else flag("command inside tRP");
                assert (cycle - last_ref >= `SDRAM_T_RFC) else flag("command inside tRFC");
            end
            case (pin_cmd)
                CMD_ACTIVE: begin
                    assert (!bank_open[ba]) else flag("ACTIVE to a bank that is already open");
                    bank_open[ba] = 1'b1;
                    open_rows[ba] = a;
                    last_act[ba]  = cycle;
                end
                CMD_READ, CMD_WRITE: begin
                    assert (bank_open[ba]) else flag("READ or WRITE to a closed bank");
                    assert (cycle - last_act[ba] >= `SDRAM_T_RCD) else
                        flag("READ or WRITE inside tRCD");
                    if (pin_cmd == CMD_READ) begin
                        read_cmds++;
                        rd_data[0] <= fetch(addr);
                    end else begin
                        assert (dq_oe) else flag("WRITE without dq_oe");
                        write_cmds++;
                        mem[addr] = dqo;
                    end
                end
                CMD_PRECHARGE: begin
                    if (a[10]) begin
                        for (int i = 0; i < `SDRAM_NUM_BANKS; i++) begin
                            bank_open[i] = 1'b0;
                        end
                    end else begin
                        bank_open[ba] = 1'b0;
                    end
                    last_pre = cycle;
                end
                CMD_REFRESH: begin
                    assert (!any_open) else flag("REFRESH while a bank is open");
                    refresh_cmds++;
                    last_ref = cycle;
                    ref_mark = cycle;
                end
                default: ;
            endcase
        end
    end

    initial begin
        protocol_errors = 0;
        read_cmds       = 0;
        write_cmds      = 0;
        refresh_cmds    = 0;
    end

endmodule

`default_nettype wire

// File: testbench/tb_sdram_controller.sv
`timescale 1ns/10ps
`default_nettype none
`include "sdram_macros.svh"

module tb_sdram_controller;
    import sdram_pkg::*;

    localparam int NUM_REQ = 400;
    localparam int TIMEOUT_CYCLES = NUM_REQ * 30 + 4 * `SDRAM_REFRESH_INTERVAL;

    logic       clk;
    logic       rst;
    logic       in_valid;
    logic       in_ready;
    logic       rw;
    user_addr_t user_addr;
    word_t      data_in;
    word_t      data_out;
    logic       out_valid;
    logic       sdram_cke;
    logic       sdram_cs;
    logic       sdram_ras;
    logic       sdram_cas;
    logic       sdram_we;
    bank_t      sdram_ba;
    pin_addr_t  sdram_a;
    word_t      sdram_dqo;
    logic       dq_oe;
    word_t      sdram_dqi;

    int protocol_errors;
    int read_cmds;
    int write_cmds;
    int refresh_cmds;

    int         errors;
    int         cycle;
    int         reads_accepted;
    int         writes_accepted;
    int         reads_done;
    logic       mode_seen;
    // reference memory and reads still owed
    word_t      ref_mem [user_addr_t];
    word_t      exp_q [$];
    sdram_cmd_e pin_cmd;

    assign pin_cmd = sdram_cmd_e'({sdram_cs, sdram_ras, sdram_cas, sdram_we});

    sdram_controller uut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .rw        (rw),
        .user_addr (user_addr),
        .data_in   (data_in),
        .data_out  (data_out),
        .out_valid (out_valid),
        .sdram_cke (sdram_cke),
        .sdram_cs  (sdram_cs),
        .sdram_ras (sdram_ras),
        .sdram_cas (sdram_cas),
        .sdram_we  (sdram_we),
        .sdram_ba  (sdram_ba),
        .sdram_a   (sdram_a),
        .sdram_dqo (sdram_dqo),
        .dq_oe     (dq_oe),
        .sdram_dqi (sdram_dqi)
    );

    sdram_chip_model chip (
        .clk             (clk),
        .rst             (rst),
        .cs              (sdram_cs),
        .ras             (sdram_ras),
        .cas             (sdram_cas),
        .we              (sdram_we),
        .ba              (sdram_ba),
        .a               (sdram_a),
        .dqo             (sdram_dqo),
        .dq_oe           (dq_oe),
        .dqi             (sdram_dqi),
        .protocol_errors (protocol_errors),
        .read_cmds       (read_cmds),
        .write_cmds      (write_cmds),
        .refresh_cmds    (refresh_cmds)
    );

    always #10 clk = ~clk;

    function automatic word_t ref_read(user_addr_t addr);
        if (ref_mem.exists(addr)) begin
            return ref_mem[addr];
        end
        return word_t'(addr) ^ 32'h5a5a5a5a;
    endfunction

    // two rows per bank and eight columns give hits, misses and conflicts
    function automatic user_addr_t pick_addr();
        row_t  row;
        bank_t bank;
        col_t  col;
        row  = ($urandom % 2 != 0) ? 13'h1a5 : 13'h0c3;
        bank = bank_t'($urandom % 4);
        col  = col_t'(($urandom % 8) * 9);
        return {row, bank, col};
    endfunction

    // entered 1 ns after a rising edge and left at the same phase
    task automatic send_request(input logic is_write, input user_addr_t addr, input word_t data);
        in_valid  = 1'b1;
        rw        = is_write;
        user_addr = addr;
        data_in   = data;
        do begin
            @(negedge clk);
        end while (!in_ready);
        @(posedge clk);
        #1;
        if (is_write) begin
            ref_mem[addr] = data;
            writes_accepted++;
        end else begin
            exp_q.push_back(ref_read(addr));
            reads_accepted++;
        end
        in_valid = 1'b0;
    endtask

    always @(posedge clk) begin
        cycle++;
        if (cycle > TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, requests or reads never completed", cycle);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // read data and start-up state sampled at the falling edge
    always @(negedge clk) begin
        word_t expected;
        if (!rst && out_valid) begin
            if (exp_q.size() == 0) begin
                assert (0) else begin
                    errors++;
                    $display("%0t out_valid pulsed with no read outstanding", $time);
                end
            end else begin
                expected = exp_q.pop_front();
                reads_done++;
                assert (data_out === expected) else begin
                    errors++;
                    $display("FAILED %0t data_out: expected %h, got %h",
                             $time, expected, data_out);
                end
            end
        end
        if (cycle > 0 && !mode_seen) begin
            if (!rst && pin_cmd == CMD_LOAD_MODE) begin
                mode_seen = 1'b1;
            end else begin
                assert (!in_ready && !out_valid && !dq_oe && !sdram_cke &&
                        (pin_cmd == CMD_NOP || pin_cmd == CMD_UNSELECTED)) else begin
                    errors++;
                    $display("%0t activity on the port or pins before the mode load", $time);
                end
            end
        end
        // clock enable high from the mode load on
        if (mode_seen) begin
            assert (sdram_cke === 1'b1) else begin
                errors++;
                $display("FAILED %0t sdram_cke: expected 1, got %b", $time, sdram_cke);
            end
        end
    end

    initial begin
        int gap;
        void'($urandom(32'hd377));
        clk             = 1'b0;
        rst             = 1'b1;
        in_valid        = 1'b0;
        rw              = 1'b0;
        user_addr       = '0;
        data_in         = '0;
        errors          = 0;
        cycle           = 0;
        reads_accepted  = 0;
        writes_accepted = 0;
        reads_done      = 0;
        mode_seen       = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < NUM_REQ; i++) begin
            gap = $urandom % 3;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            send_request($urandom % 2 != 0, pick_addr(), $urandom);
        end
        // wait for every read to return and every write to reach the chip
        while (reads_done != reads_accepted || write_cmds != writes_accepted) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);
        assert (read_cmds == reads_accepted && write_cmds == writes_accepted) else begin
            errors++;
            $display("command count mismatch: %0d reads and %0d writes accepted",
                     reads_accepted, writes_accepted);
            $display("chip saw %0d reads and %0d writes", read_cmds, write_cmds);
        end
        assert (refresh_cmds > 0) else begin
            errors++;
            $display("no refresh was issued during the run");
        end
        $display("errors: testbench %0d, protocol %0d, reads %0d, writes %0d, refreshes %0d",
                 errors, protocol_errors, reads_accepted, writes_accepted, refresh_cmds);
        if (errors == 0 && protocol_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
